// ==== exec_backend.f ====
source/exec_pkg.sv
source/exmem_stage.sv
source/load_store_unit.sv
source/data_memory.sv
source/memwb_stage.sv
source/exec_backend.sv
verification/exec_backend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the exec_backend testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

rm -rf obj_dir
if ! verilator --binary --timing --top-module exec_backend_tb -f exec_backend.f \
        -o exec_backend_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/exec_backend_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q '\*\* FAIL \*\*' "$log"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0

// ==== verification/exec_backend_tb.sv ====
// testbench for exec_backend; random ALU, load, store, mul and div traffic checked against a model
module exec_backend_tb;
    import exec_pkg::*;

    localparam int dmem_words = 256;
    localparam int mode_idle = 0;
    localparam int mode_preload = 1;
    localparam int mode_random = 2;
    localparam int random_cycles = 2000;
    localparam int wait_limit = 20;

    logic        clk;
    logic        reset;
    ex_entry_t   alu_issue;
    completion_t mul_result;
    completion_t div_result;
    completion_t alu_complete;
    completion_t mul_complete;
    completion_t div_complete;

    logic [31:0] lfsr_state;
    int          cycle_count;
    int          wait_cycles;
    // shadow of the data memory, indexed by word
    word_t       shadow [dmem_words];
    completion_t alu_q [3];
    completion_t mul_q;
    completion_t div_q;

    exec_backend #(
        .dmem_words (dmem_words)
    ) i_exec_backend (
        .clk          (clk),
        .reset        (reset),
        .alu_issue    (alu_issue),
        .mul_result   (mul_result),
        .div_result   (div_result),
        .alu_complete (alu_complete),
        .mul_complete (mul_complete),
        .div_complete (div_complete)
    );

    always #4 clk = ~clk;

    // galois LFSR, one step per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] bits;
        begin
            bits = '0;
            for (int i = 0; i < count; i++) begin
                bits = {bits[30:0], lfsr_state[0]};
                if (lfsr_state[0]) begin
                    lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
                end else begin
                    lfsr_state = lfsr_state >> 1;
                end
            end
            return bits;
        end
    endfunction

    // four-word window; bits 31:30 and 11:10 lie above the index and must alias
    function automatic word_t random_address();
        word_t addr;
        begin
            addr = '0;
            addr[3:0] = 4'(random_bits(4));
            addr[11:10] = 2'(random_bits(2));
            addr[31:30] = 2'(random_bits(2));
            return addr;
        end
    endfunction

    function automatic mem_size_t pick_size();
        begin
            case (random_bits(3) % 5)
                0: return size_byte;
                1: return size_half;
                2: return size_word;
                3: return size_byte_u;
                default: return size_half_u;
            endcase
        end
    endfunction

    function automatic word_t store_merge(word_t old, word_t data, mem_size_t f3, word_t addr);
        word_t merged;
        begin
            merged = old;
            case (f3)
                size_byte, size_byte_u: merged[{addr[1:0], 3'b000} +: 8] = data[7:0];
                size_half, size_half_u: merged[{addr[1], 4'b0000} +: 16] = data[15:0];
                default: merged = data;
            endcase
            return merged;
        end
    endfunction

    function automatic word_t load_extract(word_t stored, mem_size_t f3, word_t addr);
        logic [7:0]  b;
        logic [15:0] h;
        begin
            b = stored[{addr[1:0], 3'b000} +: 8];
            h = stored[{addr[1], 4'b0000} +: 16];
            case (f3)
                size_byte: return {{24{b[7]}}, b};
                size_half: return {{16{h[15]}}, h};
                size_byte_u: return {24'h0, b};
                size_half_u: return {16'h0, h};
                default: return stored;
            endcase
        end
    endfunction

    task automatic check_equal(input word_t actual, input word_t expected, input string what);
        begin
            if (actual !== expected) begin
                $display("CHECK FAILED at %0t: %s is %h, expected %h",
                         $time, what, actual, expected);
                $display("** FAIL **");
                $fatal(1);
            end
        end
    endtask

    task automatic check_completion(input completion_t actual, input completion_t expected,
                                    input string name);
        begin
            check_equal(32'(actual.valid), 32'(expected.valid), {name, " valid"});
            if (expected.valid) begin
                check_equal(actual.pc, expected.pc, {name, " pc"});
                check_equal(32'(actual.prd), 32'(expected.prd), {name, " prd"});
                check_equal(actual.value, expected.value, {name, " value"});
            end
        end
    endtask

    // runs at the falling edge; the entry on the inputs is taken in program order
    task automatic model_step();
        completion_t expected;
        int          idx;
        begin
            idx = int'((alu_issue.result >> 2) % dmem_words);
            expected.valid = alu_issue.valid;
            expected.pc = alu_issue.pc;
            expected.prd = alu_issue.prd;
            expected.value = alu_issue.result;
            // read before this entry's own store
            if (alu_issue.mem_to_reg) begin
                expected.value = load_extract(shadow[idx], alu_issue.funct3, alu_issue.result);
            end
            if (alu_issue.valid && alu_issue.mem_write) begin
                shadow[idx] = store_merge(shadow[idx], alu_issue.store_data, alu_issue.funct3,
                                          alu_issue.result);
            end
            alu_q[2] = alu_q[1];
            alu_q[1] = alu_q[0];
            alu_q[0] = expected;
            check_completion(alu_complete, alu_q[2], "alu_complete");
            check_completion(mul_complete, mul_q, "mul_complete");
            check_completion(div_complete, div_q, "div_complete");
            mul_q = mul_result;
            div_q = div_result;
        end
    endtask

    task automatic run_cycle(input int mode, input logic [1:0] word_sel);
        ex_entry_t   entry;
        completion_t mul_next;
        completion_t div_next;
        logic [1:0]  kind;
        begin
            entry = '0;
            mul_next = '0;
            div_next = '0;
            cycle_count++;
            if (mode == mode_preload) begin
                entry.valid = 1'b1;
                entry.mem_write = 1'b1;
                entry.funct3 = size_word;
                entry.result = random_address();
                entry.result[3:0] = {word_sel, 2'b00};
                // fill value tied to the full address
                entry.store_data = entry.result * 32'h9e37_79b1 ^ 32'h5bd1_e995;
            end else if (mode == mode_random) begin
                entry.valid = |random_bits(2);
                kind = 2'(random_bits(2));
                entry.pc = random_bits(32);
                entry.prd = 8'(random_bits(8));
                entry.funct3 = pick_size();
                entry.store_data = random_bits(32);
                entry.result = (kind == 2'd0) ? random_bits(32) : random_address();
                entry.mem_write = (kind == 2'd2);
                entry.mem_read = kind[0];
                entry.mem_to_reg = kind[0];
                mul_next.valid = 1'(random_bits(1));
                mul_next.pc = random_bits(32);
                mul_next.prd = 8'(random_bits(8));
                mul_next.value = random_bits(32);
                div_next.valid = 1'(random_bits(1));
                div_next.pc = random_bits(32);
                div_next.prd = 8'(random_bits(8));
                div_next.value = random_bits(32);
            end
            @(posedge clk);
            reset <= (cycle_count < 8);
            alu_issue <= entry;
            mul_result <= mul_next;
            div_result <= div_next;
            @(negedge clk);
            model_step();
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        alu_issue = '0;
        mul_result = '0;
        div_result = '0;
        lfsr_state = 32'haca9176a;
        cycle_count = 0;
        alu_q[0] = '0;
        alu_q[1] = '0;
        alu_q[2] = '0;
        mul_q = '0;
        div_q = '0;

        // reset, then two quiet cycles
        for (int i = 0; i < 10; i++) begin
            run_cycle(mode_idle, 2'd0);
        end

        // preload the window while the first stores travel to alu_complete
        wait_cycles = 0;
        while (!alu_complete.valid) begin
            if (wait_cycles == wait_limit) begin
                $display("timeout: no valid ALU completion arrived after reset");
                $display("** FAIL **");
                $fatal(1);
            end
            run_cycle(mode_preload, 2'(wait_cycles));
            wait_cycles++;
        end
        for (int w = wait_cycles; w < 4; w++) begin
            run_cycle(mode_preload, 2'(w));
        end

        for (int i = 0; i < random_cycles; i++) begin
            run_cycle(mode_random, 2'd0);
        end
        // drain the pipeline
        for (int i = 0; i < 3; i++) begin
            run_cycle(mode_idle, 2'd0);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== source/exec_backend.sv ====
// back end top level; joins the EX/MEM and MEM/WB stages with the data memory
module exec_backend #(
    parameter int dmem_words = 256
) (
    input  logic                  clk,
    input  logic                  reset,
    input  exec_pkg::ex_entry_t   alu_issue,
    input  exec_pkg::completion_t mul_result,
    input  exec_pkg::completion_t div_result,
    output exec_pkg::completion_t alu_complete,
    output exec_pkg::completion_t mul_complete,
    output exec_pkg::completion_t div_complete
);
    import exec_pkg::*;

    ex_entry_t   mem_req;
    word_t       load_data;
    logic [29:0] dmem_addr;
    word_t       dmem_wdata;
    word_t       dmem_rdata;
    logic [3:0]  dmem_be;
    logic        dmem_we;

    exmem_stage i_exmem_stage (
        .clk          (clk),
        .reset        (reset),
        .alu_issue    (alu_issue),
        .mul_result   (mul_result),
        .div_result   (div_result),
        .mem_req      (mem_req),
        .mul_complete (mul_complete),
        .div_complete (div_complete)
    );

    load_store_unit i_load_store_unit (
        .mem_req    (mem_req),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_we    (dmem_we),
        .load_data  (load_data)
    );

    data_memory #(
        .dmem_words (dmem_words)
    ) i_data_memory (
        .clk   (clk),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .be    (dmem_be),
        .we    (dmem_we),
        .rdata (dmem_rdata)
    );

    memwb_stage i_memwb_stage (
        .clk          (clk),
        .reset        (reset),
        .mem_req      (mem_req),
        .load_data    (load_data),
        .alu_complete (alu_complete)
    );

endmodule

// ==== source/memwb_stage.sv ====
// MEM/WB boundary; merges load results into the ALU completion for the reorder buffer
module memwb_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  exec_pkg::ex_entry_t   mem_req,
    input  exec_pkg::word_t       load_data,
    output exec_pkg::completion_t alu_complete
);
    import exec_pkg::*;

    word_t wb_value;

    // loads report memory data, everything else the ALU result
    always_comb begin
        if (mem_req.mem_to_reg) begin
            wb_value = load_data;
        end else begin
            wb_value = mem_req.result;
        end
    end

    // stores complete too, one record per valid entry
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_complete.valid <= 1'b0;
            alu_complete.pc    <= '0;
            alu_complete.prd   <= '0;
            alu_complete.value <= '0;
        end else begin
            alu_complete.valid <= mem_req.valid;
            alu_complete.pc    <= mem_req.pc;
            alu_complete.prd   <= mem_req.prd;
            alu_complete.value <= wb_value;
        end
    end

endmodule

// ==== source/data_memory.sv ====
// data memory for loads and stores; byte-enabled write at the edge, read in the same cycle
module data_memory #(
    parameter int dmem_words = 256
) (
    input  logic            clk,
    input  logic [29:0]     addr,
    input  exec_pkg::word_t wdata,
    input  logic [3:0]      be,
    input  logic            we,
    output exec_pkg::word_t rdata
);
    import exec_pkg::*;

    localparam int index_bits = $clog2(dmem_words);

    word_t                 mem [dmem_words];
    logic [index_bits-1:0] index;

    // upper word address bits alias onto the same entry
    assign index = addr[index_bits-1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[index][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // old contents seen during the write cycle
    assign rdata = mem[index];

endmodule

// ==== source/load_store_unit.sv ====
// memory stage logic; drives the data memory port and extracts load data by funct3
module load_store_unit (
    input  exec_pkg::ex_entry_t mem_req,
    input  exec_pkg::word_t     dmem_rdata,
    output logic [29:0]         dmem_addr,
    output exec_pkg::word_t     dmem_wdata,
    output logic [3:0]          dmem_be,
    output logic                dmem_we,
    output exec_pkg::word_t     load_data
);
    import exec_pkg::*;

    logic [1:0] byte_off;
    word_t      shifted;
    word_t      extended;

    assign byte_off  = mem_req.result[1:0];
    assign dmem_addr = mem_req.result[31:2];
    assign dmem_we   = mem_req.valid && mem_req.mem_write;

    // lane enables and store data placement
    always_comb begin
        case (mem_req.funct3)
            size_byte, size_byte_u: begin
                dmem_be    = 4'b0001 << byte_off;
                dmem_wdata = {4{mem_req.store_data[7:0]}};
            end
            size_half, size_half_u: begin
                // bit 0 ignored for halves
                dmem_be    = byte_off[1] ? 4'b1100 : 4'b0011;
                dmem_wdata = {2{mem_req.store_data[15:0]}};
            end
            default: begin
                dmem_be    = 4'b1111;
                dmem_wdata = mem_req.store_data;
            end
        endcase
    end

    // move the addressed lane down to bit 0
    always_comb begin
        case (mem_req.funct3)
            size_byte, size_byte_u: shifted = dmem_rdata >> {byte_off, 3'b000};
            size_half, size_half_u: shifted = dmem_rdata >> {byte_off[1], 4'b0000};
            default:                shifted = dmem_rdata;
        endcase
    end

    always_comb begin
        case (mem_req.funct3)
            size_byte:   extended = {{24{shifted[7]}}, shifted[7:0]};
            size_half:   extended = {{16{shifted[15]}}, shifted[15:0]};
            size_byte_u: extended = {24'b0, shifted[7:0]};
            size_half_u: extended = {16'b0, shifted[15:0]};
            default:     extended = shifted;
        endcase
    end

    // zero unless a load is presented
    assign load_data = mem_req.mem_read ? extended : '0;

endmodule

// ==== source/exmem_stage.sv ====
// EX/MEM boundary; holds the ALU entry for the memory stage and retires mul and div results
module exmem_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  exec_pkg::ex_entry_t   alu_issue,
    input  exec_pkg::completion_t mul_result,
    input  exec_pkg::completion_t div_result,
    output exec_pkg::ex_entry_t   mem_req,
    output exec_pkg::completion_t mul_complete,
    output exec_pkg::completion_t div_complete
);
    import exec_pkg::*;

    // ALU path entry, consumed by the memory stage next cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_req.valid      <= 1'b0;
            mem_req.pc         <= '0;
            mem_req.prd        <= '0;
            mem_req.result     <= '0;
            mem_req.store_data <= '0;
            mem_req.mem_read   <= 1'b0;
            mem_req.mem_write  <= 1'b0;
            mem_req.mem_to_reg <= 1'b0;
            mem_req.funct3     <= size_byte;
        end else begin
            mem_req <= alu_issue;
        end
    end

    // mul and div need no memory access, so they complete from here
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mul_complete.valid <= 1'b0;
            mul_complete.pc    <= '0;
            mul_complete.prd   <= '0;
            mul_complete.value <= '0;
        end else begin
            mul_complete.valid <= mul_result.valid;
            mul_complete.pc    <= mul_result.pc;
            mul_complete.prd   <= mul_result.prd;
            mul_complete.value <= mul_result.value;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_complete.valid <= 1'b0;
            div_complete.pc    <= '0;
            div_complete.prd   <= '0;
            div_complete.value <= '0;
        end else begin
            div_complete.valid <= div_result.valid;
            div_complete.pc    <= div_result.pc;
            div_complete.prd   <= div_result.prd;
            div_complete.value <= div_result.value;
        end
    end

endmodule

// ==== source/exec_pkg.sv ====
// shared types for the execution back end; stage modules import what they use from here
package exec_pkg;

    // data or address word
    typedef logic [31:0] word_t;

    // physical destination tag, matched by the reorder buffer
    typedef logic [7:0] prd_t;

    // funct3 encodings of RV32 loads and stores
    typedef enum logic [2:0] {
        size_byte   = 3'b000,
        size_half   = 3'b001,
        size_word   = 3'b010,
        size_byte_u = 3'b100,
        size_half_u = 3'b101
    } mem_size_t;

    // one entry on the ALU path, loads and stores included
    typedef struct packed {
        logic      valid;
        word_t     pc;
        prd_t      prd;
        // byte address when mem_read or mem_write is set
        word_t     result;
        word_t     store_data;
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        mem_size_t funct3;
    } ex_entry_t;

    // completion record sent to the reorder buffer
    typedef struct packed {
        logic  valid;
        word_t pc;
        prd_t  prd;
        word_t value;
    } completion_t;

endpackage
